/* project.f */
+incdir+dv
logic/mmu_pkg.sv
logic/phys_decode.sv
logic/tlb_lookup.sv
logic/mmu_port_arbiter.sv
logic/mmu_top.sv
dv/mmu_tb.sv

/* dv/mmu_model.svh */
`ifndef MMU_MODEL_SVH
`define MMU_MODEL_SVH

logic [15:0] lfsr_state = 16'd60;	// Fixed seed.
int value_errors = 0;
int other_errors = 0;
mmu_pkg::tlb_entry_t shadow [TB_ENTRIES];	// Mirrors every committed TLB write.

// Fibonacci LFSR, taps x^16 + x^14 + x^13 + x^11.
function automatic logic lfsr_step();
	logic fb;
	fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
	lfsr_state = {lfsr_state[14:0], fb};
	return fb;
endfunction

// One step per bit, right aligned.
function automatic logic [31:0] take_bits(input int n);
	logic [31:0] bits;
	bits = '0;
	for (int i = 0; i < n; i++) begin
		bits = {bits[30:0], lfsr_step()};
	end
	return bits;
endfunction

function automatic logic in_window(input logic [31:0] a, input logic [31:0] lo,
		input logic [31:0] hi);
	return (a >= lo) && (a <= hi);
endfunction

// Region of a physical address, first match wins.
function automatic mmu_pkg::dev_sel_t model_decode(input logic [31:0] pa);
	mmu_pkg::dev_sel_t sel;
	sel = mmu_pkg::DEV_NONE;
	if (in_window(pa, mmu_pkg::RAM_LO, mmu_pkg::RAM_HI)) begin
		sel = mmu_pkg::DEV_RAM;
	end else if (in_window(pa, mmu_pkg::ROM_LO, mmu_pkg::ROM_HI)) begin
		sel = mmu_pkg::DEV_ROM;
	end else if (in_window(pa, mmu_pkg::FLASH_A_LO, mmu_pkg::FLASH_A_HI) ||
			in_window(pa, mmu_pkg::FLASH_B_LO, mmu_pkg::FLASH_B_HI)) begin
		sel = mmu_pkg::DEV_FLASH;
	end else begin
		case (pa)
			mmu_pkg::UART_DATA_ADDR: sel = mmu_pkg::DEV_UART;
			mmu_pkg::UART_STAT_ADDR: sel = mmu_pkg::DEV_UART_STAT;
			mmu_pkg::DIGSEG_ADDR:    sel = mmu_pkg::DEV_DIGSEG;
			mmu_pkg::PS2_ADDR:       sel = mmu_pkg::DEV_PS2;
			default:                 sel = mmu_pkg::DEV_NONE;
		endcase
	end
	return sel;
endfunction

// Expected translation against the shadow entries.
function automatic void model_translate(input logic [31:0] vaddr, input logic write,
		output logic [31:0] paddr, output mmu_pkg::exc_t exc);
	mmu_pkg::tlb_entry_t e;
	logic found;
	logic [19:0] pfn;
	logic v;
	logic d;
	found = 1'b0;
	e = '0;
	for (int i = 0; i < TB_ENTRIES; i++) begin
		if (!found && shadow[i].vpn2 == vaddr[31:13]) begin
			found = 1'b1;	// Lowest index wins.
			e = shadow[i];
		end
	end
	pfn = vaddr[12] ? e.pfn1 : e.pfn0;
	v = vaddr[12] ? e.v1 : e.v0;
	d = vaddr[12] ? e.d1 : e.d0;
	exc = mmu_pkg::EXC_NONE;
	if (vaddr[31:30] == 2'b10) begin
		paddr = vaddr & 32'h3FFF_FFFF;
	end else if (!found || !v) begin
		paddr = 32'h0;
		exc = write ? mmu_pkg::EXC_TLBS : mmu_pkg::EXC_TLBL;
	end else begin
		paddr = {pfn, vaddr[11:0]};
		if (write && !d) begin
			exc = mmu_pkg::EXC_TLBM;
		end
	end
endfunction

`endif

/* dv/mmu_tb.sv */
`timescale 1ns/1ns

module mmu_tb;

	localparam int TB_ENTRIES = 16;
	localparam int N_RESET = 8;
	localparam int N_EARLY = 4;
	localparam int N_BYPASS = 40;
	localparam int N_HIT = 48;
	localparam int N_MISS = 24;
	localparam int N_INVALID = 8;
	localparam int N_MODIFY = 6;
	localparam int N_ARB = 200;
	localparam int N_LOOKUPS = N_EARLY + N_BYPASS + 8 + TB_ENTRIES + N_HIT + N_MISS +
		N_INVALID + 2 * N_MODIFY + N_ARB;
	localparam int N_WRITES = TB_ENTRIES + N_INVALID + N_MODIFY;
	localparam int TEST_CYCLES = N_RESET + 3 * N_LOOKUPS + N_WRITES;	// Worst case per lookup.
	localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 100;

	`include "mmu_model.svh"

	logic clk = 1'b0;
	logic rst_n;
	logic fetch_req;
	logic [31:0] fetch_vaddr;
	logic data_req;
	logic [31:0] data_vaddr;
	logic data_write;
	logic tlb_we;
	logic [$clog2(TB_ENTRIES)-1:0] tlb_index;
	mmu_pkg::tlb_entry_t tlb_entry;
	logic fetch_done;
	logic [31:0] fetch_paddr;
	mmu_pkg::dev_sel_t fetch_sel;
	mmu_pkg::exc_t fetch_exc;
	logic data_done;
	logic [31:0] data_paddr;
	mmu_pkg::dev_sel_t data_sel;
	mmu_pkg::exc_t data_exc;

	logic fetch_waiting = 1'b0;	// A request is open on that port.
	logic data_waiting = 1'b0;
	int done_count [2] = '{0, 0};
	int issued_count [2] = '{0, 0};
	logic [31:0] arb_fetch_addr [N_ARB / 2];
	logic [31:0] arb_data_addr [N_ARB / 2];
	logic arb_data_write [N_ARB / 2];

	mmu_top #(
		.TLB_ENTRIES (TB_ENTRIES)
	) dut0 (
		.clk (clk), .rst_n (rst_n),
		.fetch_req (fetch_req), .fetch_vaddr (fetch_vaddr),
		.data_req (data_req), .data_vaddr (data_vaddr), .data_write (data_write),
		.tlb_we (tlb_we), .tlb_index (tlb_index), .tlb_entry (tlb_entry),
		.fetch_done (fetch_done), .fetch_paddr (fetch_paddr),
		.fetch_sel (fetch_sel), .fetch_exc (fetch_exc),
		.data_done (data_done), .data_paddr (data_paddr),
		.data_sel (data_sel), .data_exc (data_exc)
	);

	always #4 clk = ~clk;

	// Every done pulse must belong to an open request.
	always @(negedge clk) begin
		if (fetch_done !== 1'b0) begin
			done_count[0]++;
			if (!fetch_waiting) begin
				other_errors++;
				$display("Done pulse on the fetch port with no open request at %0t", $time);
			end
		end
		if (data_done !== 1'b0) begin
			done_count[1]++;
			if (!data_waiting) begin
				other_errors++;
				$display("Done pulse on the data port with no open request at %0t", $time);
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Run timed out after %0d cycles: %0d value errors, %0d other errors",
			WATCHDOG_CYCLES, value_errors, other_errors);
		$display("STATUS: FAIL");
		$finish;
	end

	// Called and returns 1 ns after a rising edge.
	task automatic run_lookup(input mmu_pkg::port_t port, input logic [31:0] vaddr,
			input logic write, input string name);
		logic [31:0] exp_paddr;
		mmu_pkg::exc_t exp_exc;
		mmu_pkg::dev_sel_t exp_sel;
		logic got_done;
		logic [31:0] got_paddr;
		mmu_pkg::dev_sel_t got_sel;
		mmu_pkg::exc_t got_exc;
		logic eff_write;
		eff_write = (port == mmu_pkg::DATA) && write;	// Fetches only read.
		model_translate(vaddr, eff_write, exp_paddr, exp_exc);
		exp_sel = model_decode(exp_paddr);
		got_done = 1'b0;
		if (port == mmu_pkg::FETCH) begin
			fetch_req = 1'b1;
			fetch_vaddr = vaddr;
			fetch_waiting = 1'b1;
			issued_count[0]++;
		end else begin
			data_req = 1'b1;
			data_vaddr = vaddr;
			data_write = write;
			data_waiting = 1'b1;
			issued_count[1]++;
		end
		for (int w = 0; w <= 2 && !got_done; w++) begin
			@(negedge clk);
			if (port == mmu_pkg::FETCH) begin
				got_done = (fetch_done === 1'b1);
				got_paddr = fetch_paddr;
				got_sel = fetch_sel;
				got_exc = fetch_exc;
			end else begin
				got_done = (data_done === 1'b1);
				got_paddr = data_paddr;
				got_sel = data_sel;
				got_exc = data_exc;
			end
			if (got_done && w == 0) begin
				other_errors++;
				$display("%s: done for %h came in the request cycle", name, vaddr);
			end
			@(posedge clk);
			#1;
		end
		if (!got_done) begin
			other_errors++;
			$display("%s: no done within two cycles for address %h", name, vaddr);
		end else begin
			if (got_paddr !== exp_paddr) begin
				value_errors++;
				$display("[FAIL] %s: paddr for %h expected %h, got %h", name, vaddr,
					exp_paddr, got_paddr);
			end
			if (got_sel !== exp_sel) begin
				value_errors++;
				$display("[FAIL] %s: sel for %h expected %0d, got %0d", name, vaddr,
					exp_sel, got_sel);
			end
			if (got_exc !== exp_exc) begin
				value_errors++;
				$display("[FAIL] %s: exc for %h expected %0d, got %0d", name, vaddr,
					exp_exc, got_exc);
			end
		end
		if (port == mmu_pkg::FETCH) begin
			fetch_req = 1'b0;
			fetch_waiting = 1'b0;
		end else begin
			data_req = 1'b0;
			data_waiting = 1'b0;
		end
	endtask

	// Shadow follows on the edge that commits the write.
	task automatic write_entry(input int idx, input mmu_pkg::tlb_entry_t entry);
		tlb_we = 1'b1;
		tlb_index = idx[$clog2(TB_ENTRIES)-1:0];
		tlb_entry = entry;
		@(posedge clk);
		shadow[idx] = entry;
		#1;
		tlb_we = 1'b0;
	endtask

	function automatic logic [19:0] random_pfn();
		logic [31:0] r;
		if (lfsr_step()) begin
			r = take_bits(11);
			return {9'b0, r[10:0]};	// Lands in RAM.
		end
		r = take_bits(20);
		return r[19:0];
	endfunction

	function automatic mmu_pkg::tlb_entry_t random_entry(input logic v0, input logic v1);
		mmu_pkg::tlb_entry_t e;
		logic [31:0] r;
		r = take_bits(18);
		e.vpn2 = {1'b0, r[17:0]};	// Never in kseg1.
		e.pfn1 = random_pfn();
		e.d1 = lfsr_step();
		e.v1 = v1;
		e.pfn0 = random_pfn();
		e.d0 = lfsr_step();
		e.v0 = v0;
		return e;
	endfunction

	function automatic logic [31:0] pair_vaddr(input int idx);
		logic [31:0] r;
		r = take_bits(13);
		return {shadow[idx].vpn2, r[12:0]};
	endfunction

	function automatic logic [31:0] random_vaddr();
		logic [31:0] k;
		logic [31:0] r;
		k = take_bits(2);
		if (!k[1]) begin
			r = take_bits(4);
			return pair_vaddr(int'(r[3:0]));
		end
		r = take_bits(30);
		return k[0] ? {2'b10, r[29:0]} : {2'b11, r[29:0]};	// Bypass or sure miss.
	endfunction

	initial begin
		logic [31:0] r;
		mmu_pkg::tlb_entry_t e;
		rst_n = 1'b0;
		fetch_req = 1'b0;
		fetch_vaddr = '0;
		data_req = 1'b0;
		data_vaddr = '0;
		data_write = 1'b0;
		tlb_we = 1'b0;
		tlb_index = '0;
		tlb_entry = '0;
		for (int i = 0; i < TB_ENTRIES; i++) begin
			shadow[i] = '0;
		end
		repeat (N_RESET) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (2) begin
			@(posedge clk);
			#1;
		end

		// Nothing written yet, so every mapped lookup misses.
		r = take_bits(30);
		run_lookup(mmu_pkg::FETCH, {2'b00, r[29:0]}, 1'b0, "reset");
		run_lookup(mmu_pkg::DATA, {2'b01, r[29:0]}, 1'b0, "reset");
		run_lookup(mmu_pkg::DATA, {2'b11, r[29:0]}, 1'b1, "reset");
		run_lookup(mmu_pkg::DATA, 32'h0000_0000, 1'b0, "reset");

		run_lookup(mmu_pkg::DATA, 32'h8000_0000 | mmu_pkg::UART_DATA_ADDR, 1'b0, "bypass");
		run_lookup(mmu_pkg::DATA, 32'h8000_0000 | mmu_pkg::UART_STAT_ADDR, 1'b1, "bypass");
		run_lookup(mmu_pkg::DATA, 32'h8000_0000 | mmu_pkg::DIGSEG_ADDR, 1'b1, "bypass");
		run_lookup(mmu_pkg::DATA, 32'h8000_0000 | mmu_pkg::PS2_ADDR, 1'b0, "bypass");
		run_lookup(mmu_pkg::DATA, 32'h8000_0000 | mmu_pkg::ROM_HI, 1'b0, "bypass");
		run_lookup(mmu_pkg::DATA, 32'h8000_0000 | mmu_pkg::FLASH_A_LO, 1'b0, "bypass");
		run_lookup(mmu_pkg::DATA, 32'h8000_0000 | mmu_pkg::FLASH_B_HI, 1'b1, "bypass");
		run_lookup(mmu_pkg::DATA, 32'h8000_0000 | mmu_pkg::RAM_HI, 1'b0, "bypass");
		for (int i = 0; i < N_BYPASS; i++) begin
			r = take_bits(30);
			if (i % 3 == 0) begin
				r[29:23] = '0;	// Inside RAM.
			end
			run_lookup(mmu_pkg::DATA, {2'b10, r[29:0]}, lfsr_step(), "bypass");
		end

		// Lookup in the cycle right after each write.
		for (int i = 0; i < TB_ENTRIES; i++) begin
			write_entry(i, random_entry(1'b1, 1'b1));
			run_lookup(i[0] ? mmu_pkg::DATA : mmu_pkg::FETCH, pair_vaddr(i), 1'b0, "hit");
		end
		for (int i = 0; i < N_HIT; i++) begin
			r = take_bits(4);
			run_lookup(i[0] ? mmu_pkg::DATA : mmu_pkg::FETCH, pair_vaddr(int'(r[3:0])),
				1'b0, "hit");
		end

		for (int i = 0; i < N_MISS; i++) begin
			r = take_bits(30);
			run_lookup(i % 3 == 0 ? mmu_pkg::FETCH : mmu_pkg::DATA, {2'b11, r[29:0]},
				i % 3 == 2, "miss");
		end
		for (int i = 0; i < N_INVALID; i++) begin
			write_entry(i, random_entry(i[0], !i[0]));	// One half invalid.
			r = take_bits(12);
			run_lookup(i[2] ? mmu_pkg::FETCH : mmu_pkg::DATA,
				{shadow[i].vpn2, i[0], r[11:0]}, i[1], "invalid");
		end

		for (int i = 0; i < N_MODIFY; i++) begin
			e = random_entry(1'b1, 1'b1);
			e.d0 = 1'b0;
			e.d1 = 1'b1;
			write_entry(8 + i, e);
			r = take_bits(12);
			run_lookup(mmu_pkg::DATA, {e.vpn2, 1'b0, r[11:0]}, 1'b1, "modify");
			run_lookup(mmu_pkg::DATA, {e.vpn2, 1'b1, r[11:0]}, 1'b1, "modify");
		end

		// Addresses drawn up front so both ports see a fixed sequence.
		for (int i = 0; i < N_ARB / 2; i++) begin
			arb_fetch_addr[i] = random_vaddr();
			arb_data_addr[i] = random_vaddr();
			arb_data_write[i] = lfsr_step();
		end
		fork
			begin
				for (int i = 0; i < N_ARB / 2; i++) begin
					run_lookup(mmu_pkg::FETCH, arb_fetch_addr[i], 1'b0, "arbitration");
				end
			end
			begin
				for (int i = 0; i < N_ARB / 2; i++) begin
					run_lookup(mmu_pkg::DATA, arb_data_addr[i], arb_data_write[i],
						"arbitration");
				end
			end
		join
		repeat (4) @(posedge clk);

		for (int p = 0; p < 2; p++) begin
			if (done_count[p] != issued_count[p]) begin
				other_errors++;
				$display("Port %0d saw %0d done pulses for %0d requests", p,
					done_count[p], issued_count[p]);
			end
		end
		$display("Checks finished: %0d value errors, %0d other errors",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* logic/mmu_top.sv */
`timescale 1ns/1ns

module mmu_top #(
	parameter int TLB_ENTRIES = 16
) (
	input  logic                           clk,
	input  logic                           rst_n,

	input  logic                           fetch_req,
	input  logic [31:0]                    fetch_vaddr,
	input  logic                           data_req,
	input  logic [31:0]                    data_vaddr,
	input  logic                           data_write,

	input  logic                           tlb_we,
	input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_index,
	input  mmu_pkg::tlb_entry_t            tlb_entry,

	output logic                           fetch_done,
	output logic [31:0]                    fetch_paddr,
	output mmu_pkg::dev_sel_t              fetch_sel,
	output mmu_pkg::exc_t                  fetch_exc,

	output logic                           data_done,
	output logic [31:0]                    data_paddr,
	output mmu_pkg::dev_sel_t              data_sel,
	output mmu_pkg::exc_t                  data_exc
);

	logic               lookup_valid;
	mmu_pkg::mmu_req_t  lookup;
	logic               result_valid;
	mmu_pkg::mmu_resp_t result;
	logic [31:0]        paddr;	// Combinational, before the result register.
	mmu_pkg::dev_sel_t  sel;

	mmu_port_arbiter arb0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.fetch_req    (fetch_req),
		.fetch_vaddr  (fetch_vaddr),
		.data_req     (data_req),
		.data_vaddr   (data_vaddr),
		.data_write   (data_write),
		.result_valid (result_valid),
		.result       (result),
		.lookup_valid (lookup_valid),
		.lookup       (lookup),
		.fetch_done   (fetch_done),
		.fetch_paddr  (fetch_paddr),
		.fetch_sel    (fetch_sel),
		.fetch_exc    (fetch_exc),
		.data_done    (data_done),
		.data_paddr   (data_paddr),
		.data_sel     (data_sel),
		.data_exc     (data_exc)
	);

	tlb_lookup #(
		.TLB_ENTRIES (TLB_ENTRIES)
	) tlb0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.tlb_we       (tlb_we),
		.tlb_index    (tlb_index),
		.tlb_entry    (tlb_entry),
		.lookup_valid (lookup_valid),
		.lookup       (lookup),
		.sel          (sel),
		.paddr        (paddr),
		.result_valid (result_valid),
		.result       (result)
	);

	// Device select decodes in the lookup cycle.
	phys_decode dec0 (
		.paddr (paddr),
		.sel   (sel)
	);

endmodule

/* logic/mmu_port_arbiter.sv */
`timescale 1ns/1ns

module mmu_port_arbiter (
	input  logic               clk,
	input  logic               rst_n,

	input  logic               fetch_req,
	input  logic [31:0]        fetch_vaddr,
	input  logic               data_req,
	input  logic [31:0]        data_vaddr,
	input  logic               data_write,

	input  logic               result_valid,
	input  mmu_pkg::mmu_resp_t result,

	output logic               lookup_valid,
	output mmu_pkg::mmu_req_t  lookup,

	output logic               fetch_done,
	output logic [31:0]        fetch_paddr,
	output mmu_pkg::dev_sel_t  fetch_sel,
	output mmu_pkg::exc_t      fetch_exc,

	output logic               data_done,
	output logic [31:0]        data_paddr,
	output mmu_pkg::dev_sel_t  data_sel,
	output mmu_pkg::exc_t      data_exc
);

	mmu_pkg::port_t last_grant;
	logic [1:0]     in_flight;	// Indexed by port_t.
	logic           fetch_ok;
	logic           data_ok;
	logic           grant_fetch;
	logic           grant_data;

	// A port may only be granted once its previous lookup is back.
	assign fetch_ok = fetch_req && !in_flight[mmu_pkg::FETCH];
	assign data_ok = data_req && !in_flight[mmu_pkg::DATA];

	// On a tie the port granted last time waits.
	assign grant_fetch = fetch_ok && (!data_ok || last_grant == mmu_pkg::DATA);
	assign grant_data = data_ok && !grant_fetch;

	assign lookup_valid = grant_fetch || grant_data;

	always_comb begin
		if (grant_data) begin
			lookup.vaddr = data_vaddr;
			lookup.write = data_write;
			lookup.port = mmu_pkg::DATA;
		end else begin
			lookup.vaddr = fetch_vaddr;
			lookup.write = 1'b0;	// Fetches never write.
			lookup.port = mmu_pkg::FETCH;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_grant <= mmu_pkg::DATA;	// So FETCH wins the first tie.
			in_flight <= 2'b00;
		end else begin
			if (lookup_valid) begin
				last_grant <= lookup.port;
			end
			in_flight[mmu_pkg::FETCH] <= (in_flight[mmu_pkg::FETCH] || grant_fetch) &&
				!fetch_done;
			in_flight[mmu_pkg::DATA] <= (in_flight[mmu_pkg::DATA] || grant_data) &&
				!data_done;
		end
	end

	// Result steering by tag.
	assign fetch_done = result_valid && (result.port == mmu_pkg::FETCH);
	assign data_done = result_valid && (result.port == mmu_pkg::DATA);

	// Fields only mean something while the matching done is high.
	assign fetch_paddr = result.paddr;
	assign fetch_sel = result.sel;
	assign fetch_exc = result.exc;
	assign data_paddr = result.paddr;
	assign data_sel = result.sel;
	assign data_exc = result.exc;

endmodule

/* logic/tlb_lookup.sv */
`timescale 1ns/1ns

module tlb_lookup #(
	parameter int TLB_ENTRIES = 16
) (
	input  logic                                 clk,
	input  logic                                 rst_n,

	input  logic                                 tlb_we,
	input  logic [$clog2(TLB_ENTRIES)-1:0]       tlb_index,
	input  mmu_pkg::tlb_entry_t                  tlb_entry,

	input  logic                                 lookup_valid,
	input  mmu_pkg::mmu_req_t                    lookup,
	input  mmu_pkg::dev_sel_t                    sel,

	output logic [31:0]                          paddr,
	output logic                                 result_valid,
	output mmu_pkg::mmu_resp_t                   result
);

	localparam int IDX_W = $clog2(TLB_ENTRIES);

	mmu_pkg::tlb_entry_t entries [TLB_ENTRIES];

	logic                hit;
	logic [IDX_W-1:0]    hit_idx;
	mmu_pkg::tlb_entry_t hit_entry;
	logic [19:0]         page_pfn;
	logic                page_d;
	logic                page_v;
	logic                kseg1;
	mmu_pkg::exc_t       exc;

	// Entry storage. A lookup in the write cycle still reads the old entry.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < TLB_ENTRIES; i++) begin
				entries[i] <= '0;
			end
		end else if (tlb_we) begin
			entries[tlb_index] <= tlb_entry;
		end
	end

	// Associative match over every entry.
	// Scanning downwards leaves the lowest matching index in hit_idx.
	always_comb begin
		hit = 1'b0;
		hit_idx = '0;
		for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
			if (entries[i].vpn2 == lookup.vaddr[31:13]) begin
				hit = 1'b1;
				hit_idx = IDX_W'(i);
			end
		end
	end

	assign hit_entry = entries[hit_idx];
	assign kseg1 = (lookup.vaddr[31:30] == 2'b10);

	// Bit 12 picks the odd or even half of the pair.
	always_comb begin
		if (lookup.vaddr[12]) begin
			page_pfn = hit_entry.pfn1;
			page_d = hit_entry.d1;
			page_v = hit_entry.v1;
		end else begin
			page_pfn = hit_entry.pfn0;
			page_d = hit_entry.d0;
			page_v = hit_entry.v0;
		end
	end

	always_comb begin
		paddr = {page_pfn, lookup.vaddr[11:0]};
		exc = mmu_pkg::EXC_NONE;
		if (kseg1) begin
			paddr = {2'b00, lookup.vaddr[29:0]};	// Unmapped window.
		end else if (!hit || !page_v) begin
			paddr = 32'h0;
			exc = lookup.write ? mmu_pkg::EXC_TLBS : mmu_pkg::EXC_TLBL;
		end else if (lookup.write && !page_d) begin
			exc = mmu_pkg::EXC_TLBM;	// Address stays translated.
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= lookup_valid;
		end
	end

	// Result payload, captured only for a real lookup.
	always_ff @(posedge clk) begin
		if (lookup_valid) begin
			result.paddr <= paddr;
			result.sel <= sel;
			result.exc <= exc;
			result.port <= lookup.port;
		end
	end

endmodule

/* logic/phys_decode.sv */
`timescale 1ns/1ns

module phys_decode (
	input  logic [31:0]       paddr,
	output mmu_pkg::dev_sel_t sel
);

	logic in_ram;
	logic in_rom;
	logic in_flash_a;
	logic in_flash_b;

	assign in_ram = (paddr >= mmu_pkg::RAM_LO) && (paddr <= mmu_pkg::RAM_HI);
	assign in_rom = (paddr >= mmu_pkg::ROM_LO) && (paddr <= mmu_pkg::ROM_HI);
	assign in_flash_a = (paddr >= mmu_pkg::FLASH_A_LO) && (paddr <= mmu_pkg::FLASH_A_HI);
	assign in_flash_b = (paddr >= mmu_pkg::FLASH_B_LO) && (paddr <= mmu_pkg::FLASH_B_HI);

	// Priority order matters only in principle; the windows do not overlap.
	always_comb begin
		if (in_ram) begin
			sel = mmu_pkg::DEV_RAM;	// Also where exceptions land.
		end else if (in_rom) begin
			sel = mmu_pkg::DEV_ROM;
		end else if (in_flash_a || in_flash_b) begin
			sel = mmu_pkg::DEV_FLASH;	// Two flash windows.
		end else if (paddr == mmu_pkg::UART_DATA_ADDR) begin
			sel = mmu_pkg::DEV_UART;
		end else if (paddr == mmu_pkg::UART_STAT_ADDR) begin
			sel = mmu_pkg::DEV_UART_STAT;
		end else if (paddr == mmu_pkg::DIGSEG_ADDR) begin
			sel = mmu_pkg::DEV_DIGSEG;
		end else if (paddr == mmu_pkg::PS2_ADDR) begin
			sel = mmu_pkg::DEV_PS2;
		end else begin
			sel = mmu_pkg::DEV_NONE;
		end
	end

endmodule

/* logic/mmu_pkg.sv */
package mmu_pkg;

	// One TLB entry maps an even/odd pair of 4 KiB pages.
	typedef struct packed {
		logic [18:0] vpn2;	// Virtual page-pair number.
		logic [19:0] pfn1;	// Odd page frame.
		logic        d1;
		logic        v1;
		logic [19:0] pfn0;	// Even page frame.
		logic        d0;
		logic        v0;
	} tlb_entry_t;

	typedef enum logic [0:0] {
		FETCH = 1'b0,
		DATA  = 1'b1
	} port_t;

	typedef struct packed {
		logic [31:0] vaddr;
		logic        write;
		port_t       port;	// Tag of the requester.
	} mmu_req_t;

	typedef enum logic [1:0] {
		EXC_NONE = 2'd0,
		EXC_TLBL = 2'd1,	// Load or fetch miss.
		EXC_TLBS = 2'd2,	// Store miss.
		EXC_TLBM = 2'd3		// Store to clean page.
	} exc_t;

	typedef enum logic [2:0] {
		DEV_NONE      = 3'd0,
		DEV_RAM       = 3'd1,
		DEV_ROM       = 3'd2,
		DEV_FLASH     = 3'd3,
		DEV_UART      = 3'd4,
		DEV_UART_STAT = 3'd5,
		DEV_DIGSEG    = 3'd6,
		DEV_PS2       = 3'd7
	} dev_sel_t;

	typedef struct packed {
		logic [31:0] paddr;
		dev_sel_t    sel;
		exc_t        exc;
		port_t       port;
	} mmu_resp_t;

	// Physical address map, bounds inclusive.
	localparam logic [31:0] RAM_LO         = 32'h0000_0000;
	localparam logic [31:0] RAM_HI         = 32'h007F_FFFF;
	localparam logic [31:0] ROM_LO         = 32'h1FC0_0000;
	localparam logic [31:0] ROM_HI         = 32'h1FC0_0FFF;
	localparam logic [31:0] FLASH_A_LO     = 32'h1E00_0000;
	localparam logic [31:0] FLASH_A_HI     = 32'h1EFF_FFFF;
	localparam logic [31:0] FLASH_B_LO     = 32'h1A00_0000;
	localparam logic [31:0] FLASH_B_HI     = 32'h1A09_6000;
	localparam logic [31:0] UART_DATA_ADDR = 32'h1FD0_03F8;
	localparam logic [31:0] UART_STAT_ADDR = 32'h1FD0_03FC;
	localparam logic [31:0] DIGSEG_ADDR    = 32'h1FD0_0400;
	localparam logic [31:0] PS2_ADDR       = 32'h0F00_0000;

endpackage
